// File: include/img_cfg.svh
`ifndef IMG_CFG_SVH
`define IMG_CFG_SVH

// screen regions, inclusive, 1-based coordinates
`define FIRE_X0 521
`define FIRE_X1 640
`define FIRE_Y0 1
`define FIRE_Y1 120

`define WARN_X0 401
`define WARN_X1 520
`define WARN_Y0 1
`define WARN_Y1 120

// temperature tens digit
`define TENS_X0 321
`define TENS_X1 400
`define TENS_Y0 151
`define TENS_Y1 270

// temperature ones digit
`define ONES_X0 401
`define ONES_X1 480
`define ONES_Y0 151
`define ONES_Y1 270

// degree sign cell, wider than a digit
`define DEG_X0 501
`define DEG_X1 620
`define DEG_Y0 151
`define DEG_Y1 270

// glyph geometry in pixels
`define DIGIT_W 80
`define DIGIT_H 120
`define DEG_W 120
`define SEG_T 16

// 12-bit colours, r g b nibbles
`define COLOR_FG 12'hFFF
`define COLOR_FIRE 12'hF00
`define COLOR_WARN 12'hFF0
`define COLOR_BG 12'h000

`endif

// File: hdl/img_pkg.sv
package img_pkg;

  typedef struct packed {
    logic [10:0] x;
    logic [9:0]  y;
  } pix_xy_t;

  // same codes as the state machine that drives the display
  typedef enum logic [2:0] {
    SHUTDOWN = 3'b100,
    MENU     = 3'b001,
    WORKING  = 3'b010
  } disp_state_e;

  typedef struct packed {
    disp_state_e state;
    logic        is_fire;
    logic        is_warning;
    logic [3:0]  tens;   // temperature digits
    logic [3:0]  ones;
  } status_t;

  typedef enum logic [2:0] {
    REG_NONE,
    REG_FIRE,
    REG_WARN,
    REG_TENS,
    REG_ONES,
    REG_DEG
  } region_e;

  typedef struct packed {
    region_e    region;
    logic [6:0] u;      // x inside the region
    logic [6:0] v;      // y inside the region
    logic [3:0] code;   // digit for TENS/ONES
  } s1_t;

  typedef struct packed {
    region_e region;
    logic    lit;
  } s2_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // segment masks {a,b,c,d,e,f,g} for digits 0..9
  localparam logic [6:0] seg_table [10] = '{
    7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001, 7'b0110011,
    7'b1011011, 7'b1011111, 7'b1110000, 7'b1111111, 7'b1111011
  };

endpackage

// File: hdl/region_decode.sv
`timescale 1ns/1ps
`include "img_cfg.svh"

module region_decode
  import img_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  input  pix_xy_t i_pix,
  input  status_t i_status,
  output s1_t     o_s1
);

  logic [10:0] x0;       // start of the hit region
  logic [9:0]  y0;
  s1_t         s1_nxt;

  function automatic logic in_box(input pix_xy_t p, input int bx0, input int bx1,
                                  input int by0, input int by1);
    return (p.x >= bx0) && (p.x <= bx1) && (p.y >= by0) && (p.y <= by1);
  endfunction

  always_comb begin
    s1_nxt        = '0;
    s1_nxt.region = REG_NONE;
    x0            = i_pix.x;  // keeps u at 0 outside all regions
    y0            = i_pix.y;
    // only the working screen draws anything, menu renders black
    if (i_status.state == WORKING) begin
      if (i_status.is_fire && in_box(i_pix, `FIRE_X0, `FIRE_X1, `FIRE_Y0, `FIRE_Y1)) begin
        s1_nxt.region = REG_FIRE;
        x0            = 11'(`FIRE_X0);
        y0            = 10'(`FIRE_Y0);
      end else if (i_status.is_warning &&
                   in_box(i_pix, `WARN_X0, `WARN_X1, `WARN_Y0, `WARN_Y1)) begin
        s1_nxt.region = REG_WARN;
        x0            = 11'(`WARN_X0);
        y0            = 10'(`WARN_Y0);
      end else if (in_box(i_pix, `TENS_X0, `TENS_X1, `TENS_Y0, `TENS_Y1)) begin
        s1_nxt.region = REG_TENS;
        s1_nxt.code   = i_status.tens;
        x0            = 11'(`TENS_X0);
        y0            = 10'(`TENS_Y0);
      end else if (in_box(i_pix, `ONES_X0, `ONES_X1, `ONES_Y0, `ONES_Y1)) begin
        s1_nxt.region = REG_ONES;
        s1_nxt.code   = i_status.ones;
        x0            = 11'(`ONES_X0);
        y0            = 10'(`ONES_Y0);
      end else if (in_box(i_pix, `DEG_X0, `DEG_X1, `DEG_Y0, `DEG_Y1)) begin
        s1_nxt.region = REG_DEG;
        x0            = 11'(`DEG_X0);
        y0            = 10'(`DEG_Y0);
      end
    end
    s1_nxt.u = 7'(i_pix.x - x0);  // widest cell is 120, fits 7 bits
    s1_nxt.v = 7'(i_pix.y - y0);
  end

  always_ff @(posedge i_clk) begin
    o_s1 <= s1_nxt;
    if (i_rst) begin
      o_s1.region <= REG_NONE;  // payload fields keep loading
    end
  end

  // fire icon only with the flag that came in alongside the pixel
  a_fire_needs_flag: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (o_s1.region == REG_FIRE) |-> $past(i_status.is_fire)
  );

endmodule

// File: hdl/glyph_render.sv
`timescale 1ns/1ps
`include "img_cfg.svh"

module glyph_render
  import img_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst,
  input  s1_t  i_s1,
  output s2_t  o_s2
);

  localparam int MID   = `DIGIT_H / 2;       // upper/lower bar split
  localparam int G_TOP = MID - `SEG_T / 2;   // middle bar, 52..67
  localparam int G_BOT = MID + `SEG_T / 2;
  localparam logic [6:0] DEG_MASK = 7'b1001110;  // a d e f, a "C"

  logic [6:0] right_x;    // first column of the right bars
  logic       upper;
  logic       left;
  logic       right;
  logic [6:0] seg_hit;    // {a,b,c,d,e,f,g}
  logic [6:0] mask;
  logic       full_cell;
  s2_t        s2_nxt;

  // degree cell is wider, so its right bars move out
  assign right_x = (i_s1.region == REG_DEG) ? 7'(`DEG_W - `SEG_T)
                                            : 7'(`DIGIT_W - `SEG_T);
  assign upper   = (i_s1.v < MID);
  assign left    = (i_s1.u < `SEG_T);
  assign right   = (i_s1.u >= right_x);

  assign seg_hit[6] = (i_s1.v < `SEG_T);                   // a
  assign seg_hit[5] = right && upper;                       // b
  assign seg_hit[4] = right && !upper;                      // c
  assign seg_hit[3] = (i_s1.v >= `DIGIT_H - `SEG_T);       // d
  assign seg_hit[2] = left && !upper;                       // e
  assign seg_hit[1] = left && upper;                        // f
  assign seg_hit[0] = (i_s1.v >= G_TOP) && (i_s1.v < G_BOT); // g

  always_comb begin
    mask      = '0;
    full_cell = 1'b0;
    case (i_s1.region)
      REG_TENS, REG_ONES: begin
        if (i_s1.code > 4'd9) begin
          full_cell = 1'b1;  // bad digit shows a solid block
        end else begin
          mask = seg_table[i_s1.code];
        end
      end
      REG_DEG: mask = DEG_MASK;
      REG_FIRE, REG_WARN: full_cell = 1'b1;  // flat colour icons
      default: mask = '0;
    endcase
  end

  assign s2_nxt.region = i_s1.region;
  assign s2_nxt.lit    = full_cell || (|(seg_hit & mask));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_s2.region <= REG_NONE;
      o_s2.lit    <= 1'b0;
    end else begin
      o_s2 <= s2_nxt;
    end
  end

  a_none_is_dark: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (o_s2.region == REG_NONE) |-> !o_s2.lit
  );

endmodule

// File: hdl/pixel_color.sv
`timescale 1ns/1ps
`include "img_cfg.svh"

module pixel_color
  import img_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst,
  input  s2_t  i_s2,
  output rgb_t o_rgb
);

  rgb_t rgb_nxt;

  always_comb begin
    case (i_s2.region)
      REG_FIRE: rgb_nxt = rgb_t'(`COLOR_FIRE);
      REG_WARN: rgb_nxt = rgb_t'(`COLOR_WARN);
      REG_TENS, REG_ONES, REG_DEG: begin
        // glyph strokes white on black
        rgb_nxt = i_s2.lit ? rgb_t'(`COLOR_FG) : rgb_t'(`COLOR_BG);
      end
      default: rgb_nxt = rgb_t'(`COLOR_BG);
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rgb <= rgb_t'(`COLOR_BG);
    end else begin
      o_rgb <= rgb_nxt;
    end
  end

  a_black_after_rst: assert property (
    @(posedge i_clk) i_rst |=> (o_rgb == rgb_t'(`COLOR_BG))
  );

endmodule

// File: hdl/image_generator.sv
`timescale 1ns/1ps

// three stage pixel pipeline, colour lands 3 clocks after the coordinate
module image_generator
  import img_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  input  pix_xy_t i_pix,
  input  status_t i_status,
  output rgb_t    o_rgb
);

  s1_t s1;   // region + local coords
  s2_t s2;   // region + lit flag

  region_decode u_region_decode (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_pix    (i_pix),
    .i_status (i_status),
    .o_s1     (s1)
  );

  glyph_render u_glyph_render (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_s1  (s1),
    .o_s2  (s2)
  );

  pixel_color u_pixel_color (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_s2  (s2),
    .o_rgb (o_rgb)
  );

endmodule

// File: test/tb_image_generator.sv
`timescale 1ns/1ps
`include "img_cfg.svh"

module tb_image_generator;
  import img_pkg::*;

  localparam int RST_CYCLES = 3;
  localparam int N_RANDOM   = 200;
  localparam int LATENCY    = 3;
  localparam int MARGIN     = 20;

  logic    i_clk = 1'b0;
  logic    i_rst;
  pix_xy_t i_pix;
  status_t i_status;
  rgb_t    o_rgb;

  string   tbl_name[$];      // stimulus table
  status_t tbl_status[$];
  pix_xy_t tbl_pix[$];
  rgb_t    tbl_exp[$];
  string   name_q[$];        // results still in the pipeline
  rgb_t    exp_q[$];
  int      cycle_count = 0;
  int      timeout_limit = 1000;
  int      seed = 47;

  image_generator DUT (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_pix    (i_pix),
    .i_status (i_status),
    .o_rgb    (o_rgb)
  );

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Some tests failed");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "colour mismatch");
    end
  endtask

  // bit i set for segment i, a = 0 .. g = 6
  function automatic logic [6:0] digit_segments(input int d);
    case (d)
      0: return 7'b0111111;
      1: return 7'b0000110;
      2: return 7'b1011011;
      3: return 7'b1001111;
      4: return 7'b1100110;
      5: return 7'b1101101;
      6: return 7'b1111101;
      7: return 7'b0000111;
      8: return 7'b1111111;
      9: return 7'b1101111;
      default: return 7'b0000000;
    endcase
  endfunction

  function automatic bit segment_on(input int u, input int v, input int w, input int seg);
    case (seg)
      0: return v < `SEG_T;
      1: return (u >= w - `SEG_T) && (v < 60);
      2: return (u >= w - `SEG_T) && (v >= 60);
      3: return v >= `DIGIT_H - `SEG_T;
      4: return (u < `SEG_T) && (v >= 60);
      5: return (u < `SEG_T) && (v < 60);
      default: return (v >= 52) && (v < 68);  // g
    endcase
  endfunction

  function automatic bit glyph_lit(input int u, input int v, input int w, input logic [6:0] mask,
                                   input bit full);
    if (full) return 1'b1;
    for (int s = 0; s < 7; s++) begin
      if (mask[s] && segment_on(u, v, w, s)) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic bit in_region(input pix_xy_t p, input int x0, input int x1, input int y0,
                                   input int y1);
    return (p.x >= x0) && (p.x <= x1) && (p.y >= y0) && (p.y <= y1);
  endfunction

  // reference model of the whole screen
  function automatic rgb_t expected_color(input status_t st, input pix_xy_t p);
    int x;
    int y;
    x = p.x;
    y = p.y;
    if (st.state != WORKING) return rgb_t'(`COLOR_BG);
    if (st.is_fire && in_region(p, `FIRE_X0, `FIRE_X1, `FIRE_Y0, `FIRE_Y1))
      return rgb_t'(`COLOR_FIRE);
    if (st.is_warning && in_region(p, `WARN_X0, `WARN_X1, `WARN_Y0, `WARN_Y1))
      return rgb_t'(`COLOR_WARN);
    if (in_region(p, `TENS_X0, `TENS_X1, `TENS_Y0, `TENS_Y1))
      return glyph_lit(x - `TENS_X0, y - `TENS_Y0, `DIGIT_W, digit_segments(st.tens),
                       st.tens > 9) ? rgb_t'(`COLOR_FG) : rgb_t'(`COLOR_BG);
    if (in_region(p, `ONES_X0, `ONES_X1, `ONES_Y0, `ONES_Y1))
      return glyph_lit(x - `ONES_X0, y - `ONES_Y0, `DIGIT_W, digit_segments(st.ones),
                       st.ones > 9) ? rgb_t'(`COLOR_FG) : rgb_t'(`COLOR_BG);
    if (in_region(p, `DEG_X0, `DEG_X1, `DEG_Y0, `DEG_Y1))
      return glyph_lit(x - `DEG_X0, y - `DEG_Y0, `DEG_W, 7'b0111001, 1'b0)
             ? rgb_t'(`COLOR_FG) : rgb_t'(`COLOR_BG);
    return rgb_t'(`COLOR_BG);
  endfunction

  task automatic add_entry(input string name, input disp_state_e state, input logic fire,
                           input logic warn, input logic [3:0] tens, input logic [3:0] ones,
                           input int x, input int y, input rgb_t expected);
    status_t st;
    pix_xy_t p;
    st.state      = state;
    st.is_fire    = fire;
    st.is_warning = warn;
    st.tens       = tens;
    st.ones       = ones;
    p.x           = 11'(x);
    p.y           = 10'(y);
    tbl_name.push_back(name);
    tbl_status.push_back(st);
    tbl_pix.push_back(p);
    tbl_exp.push_back(expected);
  endtask

  // one pixel per clock, checked LATENCY clocks later
  task automatic apply_pixel(input string name, input status_t st, input pix_xy_t p,
                             input rgb_t expected);
    @(posedge i_clk);
    i_pix    <= p;
    i_status <= st;
    name_q.push_back(name);
    exp_q.push_back(expected);
    @(negedge i_clk);
    if (exp_q.size() > LATENCY) begin
      check_rgb(name_q.pop_front(), exp_q.pop_front(), o_rgb);
    end else begin
      check_rgb("black_after_reset", rgb_t'(`COLOR_BG), o_rgb);  // pipeline still flushing
    end
  endtask

  task automatic drain_pipeline();
    while (exp_q.size() > 0) begin
      @(posedge i_clk);
      @(negedge i_clk);
      check_rgb(name_q.pop_front(), exp_q.pop_front(), o_rgb);
    end
  endtask

  initial begin
    int         pu[8] = '{40, 72, 72, 40, 8, 8, 40, 40};  // segment centres a..g, then hole
    int         pv[8] = '{8, 30, 90, 112, 90, 30, 60, 36};
    int         qx[5] = '{600, 450, 361, 441, 508};       // one pixel in every region
    int         qy[5] = '{60, 60, 158, 158, 181};
    status_t    st;
    pix_xy_t    p;
    int         r;
    bit         on;
    logic [6:0] segs;

    st            = '0;
    st.state      = WORKING;
    st.is_fire    = 1'b1;
    p.x           = 11'd600;
    p.y           = 10'd60;
    i_rst         = 1'b1;
    i_pix         = p;   // red pixel that reset has to hide
    i_status      = st;

    add_entry("fire_first", WORKING, 1, 0, 0, 0, 600, 60, rgb_t'(`COLOR_FIRE));
    for (int i = 0; i < 5; i++) begin
      add_entry($sformatf("shutdown_%0d", i), SHUTDOWN, 1, 1, 8, 8, qx[i], qy[i], '0);
      add_entry($sformatf("menu_%0d", i), MENU, 1, 1, 8, 8, qx[i], qy[i], '0);
    end
    add_entry("fire_only_red", WORKING, 1, 0, 0, 0, 600, 60, rgb_t'(`COLOR_FIRE));
    add_entry("fire_only_warn", WORKING, 1, 0, 0, 0, 450, 60, rgb_t'(`COLOR_BG));
    add_entry("warn_only_fire", WORKING, 0, 1, 0, 0, 600, 60, rgb_t'(`COLOR_BG));
    add_entry("warn_only_yel", WORKING, 0, 1, 0, 0, 450, 60, rgb_t'(`COLOR_WARN));
    add_entry("no_alarm_fire", WORKING, 0, 0, 0, 0, 600, 60, rgb_t'(`COLOR_BG));
    add_entry("no_alarm_warn", WORKING, 0, 0, 0, 0, 450, 60, rgb_t'(`COLOR_BG));
    add_entry("both_fire", WORKING, 1, 1, 0, 0, 600, 60, rgb_t'(`COLOR_FIRE));
    add_entry("both_warn", WORKING, 1, 1, 0, 0, 450, 60, rgb_t'(`COLOR_WARN));
    for (int d = 0; d < 11; d++) begin
      segs = digit_segments(d);
      for (int k = 0; k < 8; k++) begin
        // d == 10 stands for the bad code 12
        on = (d == 10) || (k < 7 && segs[k]);
        add_entry($sformatf("tens_%0d_pt%0d", (d == 10) ? 12 : d, k), WORKING, 0, 0,
                  (d == 10) ? 12 : d, 0, `TENS_X0 + pu[k], `TENS_Y0 + pv[k],
                  on ? rgb_t'(`COLOR_FG) : rgb_t'(`COLOR_BG));
        add_entry($sformatf("ones_%0d_pt%0d", (d == 10) ? 12 : d, k), WORKING, 0, 0,
                  0, (d == 10) ? 12 : d, `ONES_X0 + pu[k], `ONES_Y0 + pv[k],
                  on ? rgb_t'(`COLOR_FG) : rgb_t'(`COLOR_BG));
      end
    end
    add_entry("deg_left_top", WORKING, 0, 0, 0, 0, 508, 181, rgb_t'(`COLOR_FG));
    add_entry("deg_left_low", WORKING, 0, 0, 0, 0, 508, 241, rgb_t'(`COLOR_FG));
    add_entry("deg_top_bar", WORKING, 0, 0, 0, 0, 561, 158, rgb_t'(`COLOR_FG));
    add_entry("deg_bottom_bar", WORKING, 0, 0, 0, 0, 561, 263, rgb_t'(`COLOR_FG));
    add_entry("deg_centre", WORKING, 0, 0, 0, 0, 561, 211, rgb_t'(`COLOR_BG));
    add_entry("deg_right_open", WORKING, 0, 0, 0, 0, 612, 181, rgb_t'(`COLOR_BG));
    add_entry("outside_corner", WORKING, 1, 1, 8, 8, 10, 10, rgb_t'(`COLOR_BG));
    add_entry("outside_gap", WORKING, 1, 1, 8, 8, 490, 210, rgb_t'(`COLOR_BG));
    add_entry("outside_low", WORKING, 1, 1, 8, 8, 640, 300, rgb_t'(`COLOR_BG));
    timeout_limit = RST_CYCLES + tbl_name.size() + N_RANDOM + LATENCY + MARGIN;

    for (int c = 0; c < RST_CYCLES; c++) begin
      @(posedge i_clk);
      if (c == RST_CYCLES - 1) begin
        i_rst    <= 1'b0;
        i_pix    <= '0;
        i_status <= '0;
      end
      @(negedge i_clk);
      check_rgb("black_in_reset", rgb_t'(`COLOR_BG), o_rgb);
    end

    for (int i = 0; i < tbl_name.size(); i++) begin
      apply_pixel(tbl_name[i], tbl_status[i], tbl_pix[i], tbl_exp[i]);
    end

    for (int i = 0; i < N_RANDOM; i++) begin
      r = $random(seed) & 32'h7fffffff;
      case (r % 5)
        0: st.state = SHUTDOWN;
        1: st.state = MENU;
        2: st.state = disp_state_e'(3'b111);  // unknown code
        default: st.state = WORKING;
      endcase
      r             = $random(seed);
      st.is_fire    = r[0];
      st.is_warning = r[1];
      st.tens       = r[7:4];
      st.ones       = r[11:8];
      p.x           = 11'(($random(seed) & 32'h7fffffff) % 700);
      p.y           = 10'(($random(seed) & 32'h7fffffff) % 300);
      apply_pixel($sformatf("random_%0d", i), st, p, expected_color(st, p));
    end

    drain_pipeline();
    $display("All tests passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
hdl/img_pkg.sv
hdl/region_decode.sv
hdl/glyph_render.sv
hdl/pixel_color.sv
hdl/image_generator.sv
test/tb_image_generator.sv
